// ==== backend.f ====
rtl/backend_pkg.sv
rtl/reg_file.sv
rtl/forwarding_unit.sv
rtl/hazard_ctrl.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/backend_top.sv
tb/backend_sva.sv
tb/backend_tb.sv

// ==== rtl/backend_pkg.sv ====
package backend_pkg;

	localparam int XLEN       = 32;
	localparam int REG_NUM    = 32;
	localparam int REG_AW     = 5;
	localparam int SHAMT_W    = 5;
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = 6;

	// bit positions in stall and clear vectors
	localparam int STAGE_EX = 0;
	localparam int STAGE_M1 = 1;
	localparam int STAGE_M2 = 2;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SLT, ADDI, LUI, LD, ST, NOP
	} op_t;

	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM} wb_sel_t;

	// which younger stage overrides an operand
	typedef enum logic [1:0] {FWD_NONE, FWD_M1, FWD_M2, FWD_WB} fwd_sel_t;

	function automatic wb_sel_t op_wb_sel(input op_t op);
		case (op)
			LD:      return WB_MEM;
			ST, NOP: return WB_NONE;
			default: return WB_ALU;
		endcase
	endfunction

	function automatic logic op_uses_rj(input op_t op);
		return !(op == LUI || op == NOP);
	endfunction

	function automatic logic op_uses_rk(input op_t op);
		return (op <= SLT) || (op == ST); // reg-reg alu ops plus store data
	endfunction

endpackage

// ==== rtl/backend_top.sv ====
`timescale 1ns/1ns

module backend_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            issue_i,
	input  backend_pkg::op_t                op_i,
	input  logic [backend_pkg::REG_AW-1:0]  rd_i,
	input  logic [backend_pkg::REG_AW-1:0]  rj_i,
	input  logic [backend_pkg::REG_AW-1:0]  rk_i,
	input  logic [backend_pkg::XLEN-1:0]    imm_i,
	output logic                            stall_o,
	output logic                            wb_valid_o,
	output logic [backend_pkg::REG_AW-1:0]  wb_addr_o,
	output logic [backend_pkg::XLEN-1:0]    wb_data_o
);
	import backend_pkg::*;

	logic [XLEN-1:0]   rf_rj_data, rf_rk_data;
	logic              ex_valid, ex_uses_rk;
	op_t               ex_op;
	logic [REG_AW-1:0] ex_rd, ex_rj, ex_rk;
	logic [XLEN-1:0]   ex_result, ex_st_data;
	logic [XLEN-1:0]   m1_result, m2_result;
	logic [REG_AW-1:0] m1_rd, m2_rd, m2_st_rd;
	logic              m1_valid, m1_load, m2_valid;
	fwd_sel_t          ex_fwd_rj, ex_fwd_rk, m2_fwd_st;
	logic              stall_ex, clr_ex;
	logic [2:0]        stall_vec, clr_vec;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_addr;
	logic [XLEN-1:0]   wb_data;

	// only EX ever holds back
	always_comb begin
		stall_vec           = '0;
		clr_vec             = '0;
		stall_vec[STAGE_EX] = stall_ex;
		clr_vec[STAGE_EX]   = clr_ex;
	end

	assign stall_o = |stall_vec;

	reg_file u_reg_file (
		.clk, .rst_n,
		.rj_addr_i (rj_i),
		.rk_addr_i (rk_i),
		.rj_data_o (rf_rj_data),
		.rk_data_o (rf_rk_data),
		.we_i      (wb_valid),
		.w_addr_i  (wb_addr),
		.w_data_i  (wb_data)
	);

	hazard_ctrl u_hazard_ctrl (
		.clk, .rst_n,
		.ex_rj_i (ex_rj), .ex_rk_i (ex_rk), .ex_uses_rk_i (ex_uses_rk), .ex_valid_i (ex_valid),
		.m1_rd_i (m1_rd), .m1_valid_i (m1_valid), .m1_load_i (m1_load),
		.m2_rd_i (m2_rd), .m2_valid_i (m2_valid),
		.wb_rd_i (wb_addr), .wb_valid_i (wb_valid),
		.ex_fwd_rj_o (ex_fwd_rj), .ex_fwd_rk_o (ex_fwd_rk),
		.m2_fwd_st_o (m2_fwd_st), .m2_st_rd_i (m2_st_rd),
		.stall_ex_o (stall_ex), .clr_ex_o (clr_ex)
	);

	ex_stage u_ex_stage (
		.clk, .rst_n, .issue_i, .stall_i (stall_vec[STAGE_EX]),
		.op_i, .rd_i, .rj_i, .rk_i, .imm_i,
		.rj_data_i (rf_rj_data), .rk_data_i (rf_rk_data),
		.fwd_rj_i (ex_fwd_rj), .fwd_rk_i (ex_fwd_rk),
		.m1_data_i (m1_result), .m2_data_i (m2_result), .wb_data_i (wb_data),
		.valid_o (ex_valid), .op_o (ex_op), .rd_o (ex_rd), .rj_o (ex_rj), .rk_o (ex_rk),
		.result_o (ex_result), .st_data_o (ex_st_data), .uses_rk_o (ex_uses_rk)
	);

	mem_stage u_mem_stage (
		.clk, .rst_n, .clr_i (clr_vec[STAGE_M1:STAGE_EX]),
		.ex_valid_i (ex_valid), .ex_op_i (ex_op), .ex_rd_i (ex_rd),
		.ex_result_i (ex_result), .ex_st_data_i (ex_st_data),
		.fwd_st_i (m2_fwd_st), .wb_data_i (wb_data),
		.m1_result_o (m1_result), .m1_rd_o (m1_rd), .m1_valid_o (m1_valid), .m1_load_o (m1_load),
		.m2_result_o (m2_result), .m2_rd_o (m2_rd), .m2_valid_o (m2_valid), .m2_st_rd_o (m2_st_rd)
	);

	// m2_valid already folds in wb_sel != WB_NONE
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
		end else if (clr_vec[STAGE_M2] || stall_vec[STAGE_M2]) begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
		end else begin
			wb_valid <= m2_valid && (m2_rd != '0);
			wb_addr  <= m2_rd;
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= m2_result;
	end

	assign wb_valid_o = wb_valid;
	assign wb_addr_o  = wb_addr;
	assign wb_data_o  = wb_data;

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            issue_i,
	input  logic                            stall_i,
	input  backend_pkg::op_t                op_i,
	input  logic [backend_pkg::REG_AW-1:0]  rd_i,
	input  logic [backend_pkg::REG_AW-1:0]  rj_i,
	input  logic [backend_pkg::REG_AW-1:0]  rk_i,
	input  logic [backend_pkg::XLEN-1:0]    imm_i,
	input  logic [backend_pkg::XLEN-1:0]    rj_data_i,
	input  logic [backend_pkg::XLEN-1:0]    rk_data_i,
	input  backend_pkg::fwd_sel_t           fwd_rj_i,
	input  backend_pkg::fwd_sel_t           fwd_rk_i,
	input  logic [backend_pkg::XLEN-1:0]    m1_data_i,
	input  logic [backend_pkg::XLEN-1:0]    m2_data_i,
	input  logic [backend_pkg::XLEN-1:0]    wb_data_i,
	output logic                            valid_o,
	output backend_pkg::op_t                op_o,
	output logic [backend_pkg::REG_AW-1:0]  rd_o,
	output logic [backend_pkg::REG_AW-1:0]  rj_o,
	output logic [backend_pkg::REG_AW-1:0]  rk_o,
	output logic [backend_pkg::XLEN-1:0]    result_o,
	output logic [backend_pkg::XLEN-1:0]    st_data_o,
	output logic                            uses_rk_o
);
	import backend_pkg::*;

	logic              ex_valid;
	op_t               ex_op;
	logic [REG_AW-1:0] ex_rd, ex_rj, ex_rk;
	logic              ex_uses_rk;
	logic [XLEN-1:0]   ex_imm;
	logic [XLEN-1:0]   ex_rj_data, ex_rk_data;
	logic [XLEN-1:0]   rj_fwd, rk_fwd;
	logic [XLEN-1:0]   alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid   <= 1'b0;
			ex_op      <= NOP;
			ex_rd      <= '0;
			ex_rj      <= '0;
			ex_rk      <= '0;
			ex_uses_rk <= 1'b0;
		end else if (!stall_i) begin
			if (issue_i) begin
				ex_valid <= 1'b1;
				ex_op    <= op_i;
				// stores carry their data register in the rd slot
				if (op_i == ST) begin
					ex_rd <= rk_i;
				end else begin
					ex_rd <= (op_wb_sel(op_i) != WB_NONE) ? rd_i : '0;
				end
				ex_rj      <= op_uses_rj(op_i) ? rj_i : '0;
				ex_rk      <= rk_i;
				ex_uses_rk <= op_uses_rk(op_i);
			end else begin
				ex_valid   <= 1'b0; // bubble
				ex_op      <= NOP;
				ex_rd      <= '0;
				ex_rj      <= '0;
				ex_rk      <= '0;
				ex_uses_rk <= 1'b0;
			end
		end
	end

	// while held, keep what was forwarded this cycle
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			ex_rj_data <= rj_data_i;
			ex_rk_data <= rk_data_i;
			ex_imm     <= imm_i;
		end else begin
			ex_rj_data <= rj_fwd;
			ex_rk_data <= rk_fwd;
		end
	end

	forwarding_unit #(.SOURCE_NUM(3)) rj_forwarding (
		.sel_i      (fwd_rj_i),
		.m1_data_i  (m1_data_i),
		.m2_data_i  (m2_data_i),
		.wb_data_i  (wb_data_i),
		.old_data_i (ex_rj_data),
		.new_data_o (rj_fwd)
	);

	forwarding_unit #(.SOURCE_NUM(3)) rk_forwarding (
		.sel_i      (fwd_rk_i),
		.m1_data_i  (m1_data_i),
		.m2_data_i  (m2_data_i),
		.wb_data_i  (wb_data_i),
		.old_data_i (ex_rk_data),
		.new_data_o (rk_fwd)
	);

	always_comb begin
		case (ex_op)
			ADD:         alu_result = rj_fwd + rk_fwd;
			SUB:         alu_result = rj_fwd - rk_fwd;
			AND:         alu_result = rj_fwd & rk_fwd;
			OR:          alu_result = rj_fwd | rk_fwd;
			XOR:         alu_result = rj_fwd ^ rk_fwd;
			SLL:         alu_result = rj_fwd << rk_fwd[SHAMT_W-1:0];
			SRL:         alu_result = rj_fwd >> rk_fwd[SHAMT_W-1:0];
			SLT:         alu_result = {{(XLEN-1){1'b0}}, $signed(rj_fwd) < $signed(rk_fwd)};
			ADDI, LD, ST: alu_result = rj_fwd + ex_imm; // agu for memory ops
			LUI:         alu_result = {ex_imm[XLEN-13:0], 12'h000};
			default:     alu_result = '0;
		endcase
	end

	assign valid_o   = ex_valid;
	assign op_o      = ex_op;
	assign rd_o      = ex_rd;
	assign rj_o      = ex_rj;
	assign rk_o      = ex_rk;
	assign uses_rk_o = ex_uses_rk;
	assign result_o  = alu_result;
	assign st_data_o = rk_fwd;

endmodule

// ==== rtl/forwarding_unit.sv ====
`timescale 1ns/1ns

module forwarding_unit #(
	parameter int SOURCE_NUM = 3
) (
	input  backend_pkg::fwd_sel_t         sel_i,
	input  logic [backend_pkg::XLEN-1:0]  m1_data_i,
	input  logic [backend_pkg::XLEN-1:0]  m2_data_i,
	input  logic [backend_pkg::XLEN-1:0]  wb_data_i,
	input  logic [backend_pkg::XLEN-1:0]  old_data_i,
	output logic [backend_pkg::XLEN-1:0]  new_data_o
);
	import backend_pkg::*;

	// sources drop from the youngest end, so one source means wb only
	always_comb begin
		new_data_o = old_data_i;
		case (sel_i)
			FWD_M1: begin
				if (SOURCE_NUM >= 3) new_data_o = m1_data_i;
			end
			FWD_M2: begin
				if (SOURCE_NUM >= 2) new_data_o = m2_data_i;
			end
			FWD_WB: begin
				if (SOURCE_NUM >= 1) new_data_o = wb_data_i;
			end
			default: new_data_o = old_data_i;
		endcase
	end

endmodule

// ==== rtl/hazard_ctrl.sv ====
`timescale 1ns/1ns

module hazard_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [backend_pkg::REG_AW-1:0]  ex_rj_i,
	input  logic [backend_pkg::REG_AW-1:0]  ex_rk_i,
	input  logic                            ex_uses_rk_i,
	input  logic                            ex_valid_i,
	input  logic [backend_pkg::REG_AW-1:0]  m1_rd_i,
	input  logic                            m1_valid_i,
	input  logic                            m1_load_i,
	input  logic [backend_pkg::REG_AW-1:0]  m2_rd_i,
	input  logic                            m2_valid_i,
	input  logic [backend_pkg::REG_AW-1:0]  wb_rd_i,
	input  logic                            wb_valid_i,
	output backend_pkg::fwd_sel_t           ex_fwd_rj_o,
	output backend_pkg::fwd_sel_t           ex_fwd_rk_o,
	output backend_pkg::fwd_sel_t           m2_fwd_st_o,
	input  logic [backend_pkg::REG_AW-1:0]  m2_st_rd_i,
	output logic                            stall_ex_o,
	output logic                            clr_ex_o
);
	import backend_pkg::*;

	logic rj_m1, rj_m2, rj_wb;
	logic rk_m1, rk_m2, rk_wb;
	logic load_use;
	logic stall_q; // EX already waited one cycle

	function automatic logic hit(input logic v, input logic [REG_AW-1:0] prod,
	                             input logic [REG_AW-1:0] src);
		return v && (prod == src) && (src != '0);
	endfunction

	// youngest producer wins; a load in M1 has no data to give yet
	function automatic fwd_sel_t pick(input logic h_m1, input logic h_m2,
	                                  input logic h_wb, input logic m1_load);
		if (h_m1) return m1_load ? FWD_NONE : FWD_M1;
		if (h_m2) return FWD_M2;
		if (h_wb) return FWD_WB;
		return FWD_NONE;
	endfunction

	assign rj_m1 = hit(m1_valid_i, m1_rd_i, ex_rj_i);
	assign rj_m2 = hit(m2_valid_i, m2_rd_i, ex_rj_i);
	assign rj_wb = hit(wb_valid_i, wb_rd_i, ex_rj_i);
	assign rk_m1 = ex_uses_rk_i && hit(m1_valid_i, m1_rd_i, ex_rk_i);
	assign rk_m2 = ex_uses_rk_i && hit(m2_valid_i, m2_rd_i, ex_rk_i);
	assign rk_wb = ex_uses_rk_i && hit(wb_valid_i, wb_rd_i, ex_rk_i);

	always_comb begin
		ex_fwd_rj_o = FWD_NONE;
		ex_fwd_rk_o = FWD_NONE;
		if (ex_valid_i) begin
			ex_fwd_rj_o = pick(rj_m1, rj_m2, rj_wb, m1_load_i);
			ex_fwd_rk_o = pick(rk_m1, rk_m2, rk_wb, m1_load_i);
		end
	end

	// store word in M2 can only be refreshed by WB
	assign m2_fwd_st_o = hit(wb_valid_i, wb_rd_i, m2_st_rd_i) ? FWD_WB : FWD_NONE;

	assign load_use   = ex_valid_i && m1_load_i && (rj_m1 || rk_m1);
	assign stall_ex_o = load_use && !stall_q;
	assign clr_ex_o   = stall_ex_o; // bubble into M1 behind the held op

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= stall_ex_o;
		end
	end

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [1:0]                      clr_i,  // bit 0 into M1, bit 1 into M2
	input  logic                            ex_valid_i,
	input  backend_pkg::op_t                ex_op_i,
	input  logic [backend_pkg::REG_AW-1:0]  ex_rd_i,
	input  logic [backend_pkg::XLEN-1:0]    ex_result_i,
	input  logic [backend_pkg::XLEN-1:0]    ex_st_data_i,
	input  backend_pkg::fwd_sel_t           fwd_st_i,
	input  logic [backend_pkg::XLEN-1:0]    wb_data_i,
	output logic [backend_pkg::XLEN-1:0]    m1_result_o,
	output logic [backend_pkg::REG_AW-1:0]  m1_rd_o,
	output logic                            m1_valid_o,
	output logic                            m1_load_o,
	output logic [backend_pkg::XLEN-1:0]    m2_result_o,
	output logic [backend_pkg::REG_AW-1:0]  m2_rd_o,
	output logic                            m2_valid_o,
	output logic [backend_pkg::REG_AW-1:0]  m2_st_rd_o
);
	import backend_pkg::*;

	logic              m1_valid;
	op_t               m1_op;
	logic [REG_AW-1:0] m1_rd;
	logic [XLEN-1:0]   m1_result, m1_st_data;
	logic [DMEM_AW-1:0] m1_idx;
	wb_sel_t           m1_wb_sel;

	logic              m2_valid;
	op_t               m2_op;
	logic [REG_AW-1:0] m2_rd;
	logic [XLEN-1:0]   m2_alu, m2_st_data, m2_rdata, m2_st_fwd;
	wb_sel_t           m2_wb_sel;

	logic [XLEN-1:0]   dmem [DMEM_WORDS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_valid <= 1'b0;
			m1_op    <= NOP;
			m1_rd    <= '0;
		end else if (clr_i[STAGE_EX]) begin
			m1_valid <= 1'b0;
			m1_op    <= NOP;
			m1_rd    <= '0;
		end else begin
			m1_valid <= ex_valid_i;
			m1_op    <= ex_op_i;
			m1_rd    <= ex_rd_i;
		end
	end

	always_ff @(posedge clk) begin
		m1_result  <= ex_result_i;
		m1_st_data <= ex_st_data_i;
	end

	assign m1_idx = m1_result[DMEM_AW+1:2]; // word index

	// store commits at the end of M1, load word lands in M2
	always_ff @(posedge clk) begin
		if (m1_valid && m1_op == ST) begin
			dmem[m1_idx] <= m1_st_data;
		end
		m2_rdata <= dmem[m1_idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m2_valid <= 1'b0;
			m2_op    <= NOP;
			m2_rd    <= '0;
		end else if (clr_i[STAGE_M1]) begin
			m2_valid <= 1'b0;
			m2_op    <= NOP;
			m2_rd    <= '0;
		end else begin
			m2_valid <= m1_valid;
			m2_op    <= m1_op;
			m2_rd    <= m1_rd;
		end
	end

	always_ff @(posedge clk) begin
		m2_alu     <= m1_result;
		m2_st_data <= m1_st_data;
	end

	assign m1_wb_sel = m1_valid ? op_wb_sel(m1_op) : WB_NONE;
	assign m2_wb_sel = m2_valid ? op_wb_sel(m2_op) : WB_NONE;

	forwarding_unit #(.SOURCE_NUM(1)) st_forwarding (
		.sel_i      (fwd_st_i),
		.m1_data_i  ('0),
		.m2_data_i  ('0),
		.wb_data_i  (wb_data_i),
		.old_data_i (m2_st_data),
		.new_data_o (m2_st_fwd)
	);

	always_comb begin
		case (m2_wb_sel)
			WB_ALU:  m2_result_o = m2_alu;
			WB_MEM:  m2_result_o = m2_rdata;
			default: m2_result_o = m2_st_fwd; // store word, never written back
		endcase
	end

	// valid toward hazard logic means "will write a register"
	assign m1_result_o = m1_result;
	assign m1_rd_o     = m1_rd;
	assign m1_valid_o  = (m1_wb_sel != WB_NONE);
	assign m1_load_o   = m1_valid && (m1_op == LD);
	assign m2_rd_o     = m2_rd;
	assign m2_valid_o  = (m2_wb_sel != WB_NONE);
	assign m2_st_rd_o  = (m2_valid && m2_op == ST) ? m2_rd : '0;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [backend_pkg::REG_AW-1:0]   rj_addr_i,
	input  logic [backend_pkg::REG_AW-1:0]   rk_addr_i,
	output logic [backend_pkg::XLEN-1:0]     rj_data_o,
	output logic [backend_pkg::XLEN-1:0]     rk_data_o,
	input  logic                             we_i,
	input  logic [backend_pkg::REG_AW-1:0]   w_addr_i,
	input  logic [backend_pkg::XLEN-1:0]     w_data_i
);
	import backend_pkg::*;

	logic [XLEN-1:0] regs [REG_NUM];
	logic            wr_en;

	assign wr_en = we_i && (w_addr_i != '0); // r0 stays zero

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[w_addr_i] <= w_data_i;
		end
	end

	// write-through so an issue in the write cycle sees the new value
	assign rj_data_o = (wr_en && w_addr_i == rj_addr_i) ? w_data_i : regs[rj_addr_i];
	assign rk_data_o = (wr_en && w_addr_i == rk_addr_i) ? w_data_i : regs[rk_addr_i];

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f backend.f --top-module backend_tb -o backend_sim
./obj_dir/backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

// ==== tb/backend_sva.sv ====
`timescale 1ns/1ns

module backend_sva (
	input logic       clk,
	input logic       rst_n,
	input logic       stall_o,
	input logic       wb_valid_o,
	input logic       ex_valid,
	input logic       m1_valid,
	input logic       m2_valid,
	input logic [2:0] stall_vec,
	input logic [2:0] clr_vec
);

	// load-use stall lasts a single cycle
	single_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall_o |=> !stall_o)
	else $error("stall held for two cycles");

	// held op leaves a bubble behind in M1
	bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall_o |=> !m1_valid)
	else $error("valid entered M1 after a stall");

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !(stall_o || wb_valid_o || ex_valid || m1_valid || m2_valid ||
		                   |stall_vec || |clr_vec))
	else $error("pipeline not idle after reset");

endmodule

bind backend_top backend_sva backend_sva0 (
	.clk, .rst_n, .stall_o, .wb_valid_o,
	.ex_valid, .m1_valid, .m2_valid, .stall_vec, .clr_vec
);

// ==== tb/backend_tb.sv ====
`timescale 1ns/1ns

module backend_tb;
	import backend_pkg::*;

	logic              clk;
	logic              rst_n;
	logic              issue_i;
	op_t               op_i;
	logic [REG_AW-1:0] rd_i, rj_i, rk_i;
	logic [XLEN-1:0]   imm_i;
	logic              stall_o;
	logic              wb_valid_o;
	logic [REG_AW-1:0] wb_addr_o;
	logic [XLEN-1:0]   wb_data_o;

	logic [XLEN-1:0]   model_regs [REG_NUM];
	logic [XLEN-1:0]   model_mem [DMEM_WORDS];
	logic [15:0]       lfsr;
	logic [REG_AW+XLEN-1:0] exp_q [$]; // {addr, data} in program order
	logic              head_ok;
	logic [REG_AW-1:0] head_addr;
	logic [XLEN-1:0]   head_data;
	int                errors, checked, issued, cycles, stalls_seen;

	backend_top dut0 (
		.clk, .rst_n, .issue_i, .op_i, .rd_i, .rj_i, .rk_i, .imm_i,
		.stall_o, .wb_valid_o, .wb_addr_o, .wb_data_o
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [REG_AW-1:0] rand_reg();
		logic [31:0] r;
		r = rand_bits(REG_AW);
		return r[REG_AW-1:0];
	endfunction

	function automatic logic [XLEN-1:0] expect_alu(input op_t op, input logic [XLEN-1:0] a,
	                                              input logic [XLEN-1:0] b,
	                                              input logic [XLEN-1:0] imm);
		case (op)
			ADD:  return a + b;
			SUB:  return a - b;
			AND:  return a & b;
			OR:   return a | b;
			XOR:  return a ^ b;
			SLL:  return a << b[4:0];
			SRL:  return a >> b[4:0];
			SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ADDI: return a + imm;
			LUI:  return imm << 12;
			default: return '0;
		endcase
	endfunction

	// drive one instruction, hold it through stalls, update the model
	task automatic issue(input op_t op, input logic [4:0] rd, input logic [4:0] rj,
	                     input logic [4:0] rk, input logic [XLEN-1:0] imm);
		logic             st;
		logic [XLEN-1:0]  val;
		logic [DMEM_AW-1:0] idx;
		issue_i = 1'b1;
		op_i    = op;
		rd_i    = rd;
		rj_i    = rj;
		rk_i    = rk;
		imm_i   = imm;
		idx     = imm[DMEM_AW+1:2]; // memory ops always use r0 as base
		if (op == ST) begin
			model_mem[idx] = model_regs[rk];
		end else if (op != NOP) begin
			val = (op == LD) ? model_mem[idx] : expect_alu(op, model_regs[rj], model_regs[rk], imm);
			if (rd != 0) begin
				model_regs[rd] = val;
				exp_q.push_back({rd, val});
			end
		end
		issued++;
		do begin
			@(negedge clk);
			st = stall_o;
			@(posedge clk);
			#1;
		end while (st);
		issue_i = 1'b0;
	endtask

	task automatic drain_and_report(input string name, input int err_before);
		while (exp_q.size() != 0) @(posedge clk);
		repeat (3) @(posedge clk);
		#1;
		$display("test %s done, %0d writes checked so far, %0d new errors",
		         name, checked, errors - err_before);
	endtask

	function automatic logic [4:0] pick_reg_except(input logic [4:0] avoid);
		logic [4:0] r;
		r = rand_reg();
		if (r == avoid || r == 0) r = avoid + 5'd7;
		if (r == 0) r = 5'd3;
		return r;
	endfunction

	always @(negedge clk) begin
		head_ok = exp_q.size() != 0;
		if (head_ok) begin
			head_addr = exp_q[0][REG_AW+XLEN-1:XLEN];
			head_data = exp_q[0][XLEN-1:0];
		end
	end

	// every stall cycle, whether or not an issue is waiting
	always @(negedge clk) begin
		if (rst_n && stall_o) stalls_seen++;
	end

	always @(posedge clk) begin
		if (rst_n && wb_valid_o && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			checked++;
		end
	end

	wb_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid_o |-> (head_ok && wb_addr_o == head_addr && wb_data_o == head_data))
	else begin
		$display("FAILED at %0t: write r%0d = %h, expected r%0d = %h", $time,
		         wb_addr_o, wb_data_o, head_addr, head_data);
		errors++;
	end

	idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> (!stall_o && !wb_valid_o))
	else begin
		$display("FAILED at %0t: stall or write-back active right after reset", $time);
		errors++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 20 * issued + 50) begin
			$display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		int e0;
		logic [4:0] x, y;
		rst_n = 1'b0;
		issue_i = 1'b0;
		op_i = NOP;
		rd_i = '0;
		rj_i = '0;
		rk_i = '0;
		imm_i = '0;
		lfsr = 16'd62;
		errors = 0;
		checked = 0;
		issued = 0;
		cycles = 0;
		stalls_seen = 0;
		for (int i = 0; i < REG_NUM; i++) model_regs[i] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		e0 = errors;
		for (int i = 0; i < 40; i++) begin
			issue(op_t'(rand_bits(4) % 10), rand_reg(), rand_reg(), rand_reg(),
			      rand_bits(16));
		end
		drain_and_report("alu_ops", e0);

		e0 = errors;
		for (int d = 1; d <= 3; d++) begin
			for (int i = 0; i < 8; i++) begin
				x = pick_reg_except(0);
				issue(ADDI, x, rand_reg(), 0, rand_bits(16));
				for (int f = 1; f < d; f++) issue(XOR, pick_reg_except(x), rand_reg(), 5'd1, 0);
				issue(op_t'(rand_bits(3)), pick_reg_except(0), x, (i % 2) ? x : rand_reg(), 0);
			end
		end
		drain_and_report("forwarding", e0);

		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			x = pick_reg_except(0);
			y = pick_reg_except(x);
			issue(ADDI, x, rand_reg(), 0, rand_bits(16)); // data forwarded into the store
			issue(ST, 0, 0, x, i * 4);
			issue(LD, y, 0, 0, i * 4);
		end
		drain_and_report("store_load", e0);

		e0 = errors;
		stalls_seen = 0;
		for (int i = 0; i < 8; i++) begin
			x = pick_reg_except(0);
			issue(LD, x, 0, 0, rand_bits(3) * 4);
			if (i % 2) issue(ADD, pick_reg_except(0), x, rand_reg(), 0);
			else issue(SUB, pick_reg_except(0), rand_reg(), x, 0);
		end
		drain_and_report("load_use", e0);
		if (stalls_seen != 8) begin
			$display("FAILED at %0t: load-use test saw %0d stall cycles, expected 8",
			         $time, stalls_seen);
			errors++;
		end

		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			issue(ADDI, 0, rand_reg(), 0, rand_bits(16)); // must not reach write-back
			issue(ADD, pick_reg_except(0), 0, 0, 0);
		end
		drain_and_report("r0", e0);

		if (errors == 0 && exp_q.size() == 0) begin
			$display("summary: %0d issued, %0d writes checked, 0 errors", issued, checked);
			$display("NO ERRORS");
		end else begin
			$display("summary: %0d issued, %0d writes checked, %0d errors, %0d writes missing",
			         issued, checked, errors, exp_q.size());
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
